// ==== src/cpuPkg.sv ====
// ==========================================================
// CPU back end package
// Widths and code points shared by the MEM2 and WB stages.
// ==========================================================

`default_nettype none

package cpuPkg;

    // ==========================================================
    // Widths
    // ==========================================================
    localparam int DataWidth     = 32;
    localparam int RegAddrWidth  = 5;
    localparam int LoadTypeWidth = 3;
    localparam int WbSelWidth    = 2;
    localparam int RegsWrWidth   = 3;

    // ==========================================================
    // Load types
    // ==========================================================
    // Byte and half loads pick their lane from the low address bits.
    localparam logic [LoadTypeWidth-1:0] LoadWord  = 3'd0;
    localparam logic [LoadTypeWidth-1:0] LoadByte  = 3'd1;
    localparam logic [LoadTypeWidth-1:0] LoadByteU = 3'd2;
    localparam logic [LoadTypeWidth-1:0] LoadHalf  = 3'd3;
    localparam logic [LoadTypeWidth-1:0] LoadHalfU = 3'd4;

    // ==========================================================
    // Writeback select codes
    // ==========================================================
    localparam logic [WbSelWidth-1:0] WbSelLink = 2'd0;
    localparam logic [WbSelWidth-1:0] WbSelAlu  = 2'd1;
    localparam logic [WbSelWidth-1:0] WbSelOutB = 2'd2;
    localparam logic [WbSelWidth-1:0] WbSelMem  = 2'd3;

    // Bit positions inside the register write type.
    localparam int RegsWrRf = 0;
    localparam int RegsWrHi = 1;
    localparam int RegsWrLo = 2;

    // Return address offset for linking jumps.
    localparam logic [DataWidth-1:0] LinkOffset = 32'd8;

endpackage

`default_nettype wire

// ==== src/Mem2WbIf.sv ====
// ==========================================================
// MEM2 to WB interface
// Carries one instruction from the second memory stage.
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

interface Mem2WbIf;
    import cpuPkg::*;

    // Payload.
    logic [DataWidth-1:0]    aluOut;
    logic [DataWidth-1:0]    pc;
    logic [DataWidth-1:0]    outB;
    logic [DataWidth-1:0]    dmOut;

    // Control. An empty slot has regsWr at zero.
    logic [WbSelWidth-1:0]   wbSel;
    logic [RegAddrWidth-1:0] dst;
    logic [RegsWrWidth-1:0]  regsWr;

    modport producer (
        output aluOut,
        output pc,
        output outB,
        output dmOut,
        output wbSel,
        output dst,
        output regsWr
    );

    modport consumer (
        input aluOut,
        input pc,
        input outB,
        input dmOut,
        input wbSel,
        input dst,
        input regsWr
    );

endinterface

`default_nettype wire

// ==== src/Mem2Stage.sv ====
// ==========================================================
// MEM2 stage
// Registers the instruction and aligns the loaded data.
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module Mem2Stage (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             wr,
    input  logic [cpuPkg::DataWidth-1:0]     aluOut,
    input  logic [cpuPkg::DataWidth-1:0]     pc,
    input  logic [cpuPkg::DataWidth-1:0]     outB,
    input  logic [cpuPkg::DataWidth-1:0]     memData,
    input  logic [cpuPkg::LoadTypeWidth-1:0] loadType,
    input  logic [cpuPkg::WbSelWidth-1:0]    wbSel,
    input  logic [cpuPkg::RegAddrWidth-1:0]  dst,
    input  logic [cpuPkg::RegsWrWidth-1:0]   regsWr,
    Mem2WbIf.producer                        m2wb
);
    import cpuPkg::*;

    logic [DataWidth-1:0]     aluOutQ;
    logic [DataWidth-1:0]     pcQ;
    logic [DataWidth-1:0]     outBQ;
    logic [DataWidth-1:0]     memDataQ;
    logic [LoadTypeWidth-1:0] loadTypeQ;
    logic [WbSelWidth-1:0]    wbSelQ;
    logic [RegAddrWidth-1:0]  dstQ;
    logic [RegsWrWidth-1:0]   regsWrQ;
    logic [7:0]               loadByte;
    logic [15:0]              loadHalf;

    // ==========================================================
    // Stage register, held while wr is low.
    // ==========================================================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aluOutQ   <= '0;
            pcQ       <= '0;
            outBQ     <= '0;
            memDataQ  <= '0;
            loadTypeQ <= '0;
            wbSelQ    <= '0;
            dstQ      <= '0;
            regsWrQ   <= '0;
        end else if (wr) begin
            aluOutQ   <= aluOut;
            pcQ       <= pc;
            outBQ     <= outB;
            memDataQ  <= memData;
            loadTypeQ <= loadType;
            wbSelQ    <= wbSel;
            dstQ      <= dst;
            regsWrQ   <= regsWr;
        end
    end

    // ==========================================================
    // Load alignment, little-endian lanes.
    // ==========================================================
    always_comb begin
        case (aluOutQ[1:0])
            2'd0:    loadByte = memDataQ[7:0];
            2'd1:    loadByte = memDataQ[15:8];
            2'd2:    loadByte = memDataQ[23:16];
            default: loadByte = memDataQ[31:24];
        endcase
        loadHalf = aluOutQ[1] ? memDataQ[31:16] : memDataQ[15:0];

        case (loadTypeQ)
            LoadByte:  m2wb.dmOut = {{(DataWidth-8){loadByte[7]}}, loadByte};
            LoadByteU: m2wb.dmOut = {{(DataWidth-8){1'b0}}, loadByte};
            LoadHalf:  m2wb.dmOut = {{(DataWidth-16){loadHalf[15]}}, loadHalf};
            LoadHalfU: m2wb.dmOut = {{(DataWidth-16){1'b0}}, loadHalf};
            // Words and unused codes pass the whole word.
            default:   m2wb.dmOut = memDataQ;
        endcase
    end

    assign m2wb.aluOut = aluOutQ;
    assign m2wb.pc     = pcQ;
    assign m2wb.outB   = outBQ;
    assign m2wb.wbSel  = wbSelQ;
    assign m2wb.dst    = dstQ;
    assign m2wb.regsWr = regsWrQ;

endmodule

`default_nettype wire

// ==== src/WbReg.sv ====
// ==========================================================
// WB pipeline register
// Captures MEM2 fields, with stall hold and flush to bubble.
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module WbReg (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            flush,
    input  logic                            wr,
    Mem2WbIf.consumer                       m2wb,
    output logic [cpuPkg::DataWidth-1:0]    aluOut,
    output logic [cpuPkg::DataWidth-1:0]    pc,
    output logic [cpuPkg::DataWidth-1:0]    outB,
    output logic [cpuPkg::DataWidth-1:0]    dmOut,
    output logic [cpuPkg::WbSelWidth-1:0]   wbSel,
    output logic [cpuPkg::RegAddrWidth-1:0] dst,
    output logic [cpuPkg::RegsWrWidth-1:0]  regsWr
);

    // Flush wins over wr and loads an all-zero bubble.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aluOut <= '0;
            pc     <= '0;
            outB   <= '0;
            dmOut  <= '0;
            wbSel  <= '0;
            dst    <= '0;
            regsWr <= '0;
        end else if (flush) begin
            aluOut <= '0;
            pc     <= '0;
            outB   <= '0;
            dmOut  <= '0;
            wbSel  <= '0;
            dst    <= '0;
            regsWr <= '0;
        end else if (wr) begin
            aluOut <= m2wb.aluOut;
            pc     <= m2wb.pc;
            outB   <= m2wb.outB;
            dmOut  <= m2wb.dmOut;
            wbSel  <= m2wb.wbSel;
            dst    <= m2wb.dst;
            regsWr <= m2wb.regsWr;
        end
    end

endmodule

`default_nettype wire

// ==== src/WbStage.sv ====
// ==========================================================
// WB stage
// Picks the writeback result and gates the final write.
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module WbStage (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            flush,
    input  logic                            wr,
    input  logic                            disWr,
    Mem2WbIf.consumer                       m2wb,
    output logic [cpuPkg::DataWidth-1:0]    result,
    output logic [cpuPkg::RegAddrWidth-1:0] dst,
    output logic [cpuPkg::RegsWrWidth-1:0]  regsWr,
    output logic [cpuPkg::RegsWrWidth-1:0]  finalWr,
    output logic [cpuPkg::DataWidth-1:0]    pc
);
    import cpuPkg::*;

    logic [DataWidth-1:0]  wbAluOut;
    logic [DataWidth-1:0]  wbOutB;
    logic [DataWidth-1:0]  wbDmOut;
    logic [WbSelWidth-1:0] wbSel;

    WbReg uWbReg (
        .clk    (clk),
        .rstN   (rstN),
        .flush  (flush),
        .wr     (wr),
        .m2wb   (m2wb),
        .aluOut (wbAluOut),
        .pc     (pc),
        .outB   (wbOutB),
        .dmOut  (wbDmOut),
        .wbSel  (wbSel),
        .dst    (dst),
        .regsWr (regsWr)
    );

    // ==========================================================
    // Result select
    // ==========================================================
    always_comb begin
        case (wbSel)
            WbSelLink: result = pc + LinkOffset;   // jal, jalr return address
            WbSelAlu:  result = wbAluOut;
            WbSelOutB: result = wbOutB;            // mthi, mtlo style moves
            default:   result = wbDmOut;
        endcase
    end

    // A data-cache stall blocks the write in the same cycle.
    assign finalWr = disWr ? '0 : regsWr;

endmodule

`default_nettype wire

// ==== src/RegFile.sv ====
// ==========================================================
// Register file
// 32 GPRs plus HI and LO, two read ports with bypass.
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module RegFile (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [cpuPkg::RegsWrWidth-1:0]  wrType,
    input  logic [cpuPkg::RegAddrWidth-1:0] wrAddr,
    input  logic [cpuPkg::DataWidth-1:0]    wrData,
    input  logic [cpuPkg::RegAddrWidth-1:0] rsAddr,
    input  logic [cpuPkg::RegAddrWidth-1:0] rtAddr,
    output logic [cpuPkg::DataWidth-1:0]    rsData,
    output logic [cpuPkg::DataWidth-1:0]    rtData,
    output logic [cpuPkg::DataWidth-1:0]    hiData,
    output logic [cpuPkg::DataWidth-1:0]    loData
);
    import cpuPkg::*;

    // Register 0 has no storage.
    logic [DataWidth-1:0] gpr [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                gpr[i] <= '0;
            end
            hiData <= '0;
            loData <= '0;
        end else begin
            if (wrType[RegsWrRf] && wrAddr != '0) begin
                gpr[wrAddr] <= wrData;
            end
            if (wrType[RegsWrHi]) begin
                hiData <= wrData;
            end
            if (wrType[RegsWrLo]) begin
                loData <= wrData;
            end
        end
    end

    // Read with bypass of the write pending this cycle.
    function automatic logic [DataWidth-1:0] readReg(input logic [RegAddrWidth-1:0] addr);
        logic [DataWidth-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wrType[RegsWrRf] && addr == wrAddr) begin
            value = wrData;
        end else begin
            value = gpr[addr];
        end
        return value;
    endfunction

    always_comb begin
        rsData = readReg(rsAddr);
        rtData = readReg(rtAddr);
    end

endmodule

`default_nettype wire

// ==== src/WritebackTop.sv ====
// ==========================================================
// Pipeline back end top
// MEM2 and WB stages feeding the register file.
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module WritebackTop (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             wr,
    input  logic                             flush,
    input  logic                             disWr,
    input  logic [cpuPkg::DataWidth-1:0]     aluOut,
    input  logic [cpuPkg::DataWidth-1:0]     pc,
    input  logic [cpuPkg::DataWidth-1:0]     outB,
    input  logic [cpuPkg::DataWidth-1:0]     memData,
    input  logic [cpuPkg::LoadTypeWidth-1:0] loadType,
    input  logic [cpuPkg::WbSelWidth-1:0]    wbSel,
    input  logic [cpuPkg::RegAddrWidth-1:0]  dst,
    input  logic [cpuPkg::RegsWrWidth-1:0]   regsWr,
    input  logic [cpuPkg::RegAddrWidth-1:0]  rsAddr,
    input  logic [cpuPkg::RegAddrWidth-1:0]  rtAddr,
    output logic [cpuPkg::DataWidth-1:0]     wbResult,
    output logic [cpuPkg::RegAddrWidth-1:0]  wbDst,
    output logic [cpuPkg::RegsWrWidth-1:0]   wbRegsWr,
    output logic [cpuPkg::RegsWrWidth-1:0]   wbFinalWr,
    output logic [cpuPkg::DataWidth-1:0]     wbPc,
    output logic [cpuPkg::DataWidth-1:0]     rsData,
    output logic [cpuPkg::DataWidth-1:0]     rtData,
    output logic [cpuPkg::DataWidth-1:0]     hiData,
    output logic [cpuPkg::DataWidth-1:0]     loData
);

    Mem2WbIf m2wb ();

    Mem2Stage uMem2 (
        .clk      (clk),
        .rstN     (rstN),
        .wr       (wr),
        .aluOut   (aluOut),
        .pc       (pc),
        .outB     (outB),
        .memData  (memData),
        .loadType (loadType),
        .wbSel    (wbSel),
        .dst      (dst),
        .regsWr   (regsWr),
        .m2wb     (m2wb.producer)
    );

    WbStage uWb (
        .clk     (clk),
        .rstN    (rstN),
        .flush   (flush),
        .wr      (wr),
        .disWr   (disWr),
        .m2wb    (m2wb.consumer),
        .result  (wbResult),
        .dst     (wbDst),
        .regsWr  (wbRegsWr),
        .finalWr (wbFinalWr),
        .pc      (wbPc)
    );

    // Commit port is driven by the gated write type.
    RegFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .wrType (wbFinalWr),
        .wrAddr (wbDst),
        .wrData (wbResult),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData),
        .hiData (hiData),
        .loData (loData)
    );

endmodule

`default_nettype wire

// ==== verif/wbStage_properties.sv ====
// ==========================================================
// WB stage properties
// Write gating, flush and stall hold, bound to WbStage.
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module wbStageProperties (
    input logic                            clk,
    input logic                            rstN,
    input logic                            flush,
    input logic                            wr,
    input logic                            disWr,
    input logic [cpuPkg::DataWidth-1:0]    result,
    input logic [cpuPkg::RegAddrWidth-1:0] dst,
    input logic [cpuPkg::RegsWrWidth-1:0]  regsWr,
    input logic [cpuPkg::RegsWrWidth-1:0]  finalWr,
    input logic [cpuPkg::DataWidth-1:0]    pc
);

    // A data-cache stall blocks the write.
    noWriteOnStall: assert property (@(posedge clk) disable iff (!rstN)
        disWr |-> finalWr == '0)
        else $error("final write active while the data cache stalls");

    flushClears: assert property (@(posedge clk) disable iff (!rstN)
        flush |=> regsWr == '0)
        else $error("write type not cleared after a flush");

    // Held stage keeps every registered field.
    holdOnStall: assert property (@(posedge clk) disable iff (!rstN)
        (!wr && !flush) |=> ($stable(result) && $stable(dst) && $stable(regsWr) && $stable(pc)))
        else $error("WB fields changed while the stage was held");

endmodule

bind WbStage wbStageProperties uWbProps (
    .clk     (clk),
    .rstN    (rstN),
    .flush   (flush),
    .wr      (wr),
    .disWr   (disWr),
    .result  (result),
    .dst     (dst),
    .regsWr  (regsWr),
    .finalWr (finalWr),
    .pc      (pc)
);

`default_nettype wire

// ==== verif/tbWriteback.sv ====
// ==========================================================
// Writeback back end testbench
// Directed tests against a register model of the pipeline.
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module tbWriteback;
    import cpuPkg::*;

    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 5;
    // 21 single instructions of 4 cycles, then pipeline, stall and flush tests.
    localparam int TestCycles  = ResetCycles + 21 * 4 + 10 + 10 + 5;
    localparam int MarginCycles = 50;
    localparam logic [RegsWrWidth-1:0] WrRf = 3'(1 << RegsWrRf);
    localparam logic [RegsWrWidth-1:0] WrHi = 3'(1 << RegsWrHi);
    localparam logic [RegsWrWidth-1:0] WrLo = 3'(1 << RegsWrLo);

    logic                     clk;
    logic                     rstN;
    logic                     wr;
    logic                     flush;
    logic                     disWr;
    logic [DataWidth-1:0]     aluOut, pc, outB, memData;
    logic [LoadTypeWidth-1:0] loadType;
    logic [WbSelWidth-1:0]    wbSel;
    logic [RegAddrWidth-1:0]  dst, rsAddr, rtAddr, wbDst;
    logic [RegsWrWidth-1:0]   regsWr, wbRegsWr, wbFinalWr;
    logic [DataWidth-1:0]     wbResult, wbPc, rsData, rtData, hiData, loData;
    logic [DataWidth-1:0]     modelRegs [32];
    logic [DataWidth-1:0]     modelHi;
    logic [DataWidth-1:0]     modelLo;
    logic [31:0]              seed = 32'd30158;
    int                       checkCount = 0;
    int                       errorCount = 0;

    WritebackTop i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #((TestCycles + MarginCycles) * ClkPeriod);
        $display("Watchdog timeout: the tests did not finish in their cycle budget");
        $display("Done: errors found");
        $finish;
    end

    // ==========================================================
    // Reference rules
    // ==========================================================
    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [RegAddrWidth-1:0] randReg();
        return 5'(((nextRand() >> 8) % 31) + 1);
    endfunction

    // Little-endian lane pick, then extension by load type.
    function automatic logic [31:0] alignLoad(input logic [2:0] lt, input logic [1:0] off,
                                              input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> {off, 3'b000});
        h = off[1] ? word[31:16] : word[15:0];
        case (lt)
            LoadByte:  return {{24{b[7]}}, b};
            LoadByteU: return {24'h0, b};
            LoadHalf:  return {{16{h[15]}}, h};
            LoadHalfU: return {16'h0, h};
            default:   return word;
        endcase
    endfunction

    function automatic logic [31:0] expectedResult(input logic [1:0] sel, input logic [31:0] alu,
                                                   input logic [31:0] pcV, input logic [31:0] ob,
                                                   input logic [31:0] memV);
        case (sel)
            WbSelLink: return pcV + LinkOffset;
            WbSelAlu:  return alu;
            WbSelOutB: return ob;
            default:   return memV;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("** Error: %s expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic setInputs(input logic [31:0] alu, input logic [31:0] pcV,
                             input logic [31:0] ob, input logic [31:0] mem,
                             input logic [2:0] lt, input logic [1:0] sel,
                             input logic [4:0] d, input logic [2:0] rw);
        aluOut   = alu;
        pc       = pcV;
        outB     = ob;
        memData  = mem;
        loadType = lt;
        wbSel    = sel;
        dst      = d;
        regsWr   = rw;
    endtask

    task automatic commitModel(input logic [4:0] d, input logic [2:0] rw,
                               input logic [31:0] value);
        if (rw[RegsWrRf] && d != 5'd0) begin
            modelRegs[d] = value;
        end
        if (rw[RegsWrHi]) begin
            modelHi = value;
        end
        if (rw[RegsWrLo]) begin
            modelLo = value;
        end
    endtask

    task automatic checkReg(input logic [4:0] addr);
        @(posedge clk);
        #2;
        rsAddr = addr;
        rtAddr = addr;
        @(negedge clk);
        checkValue("rsData", rsData, modelRegs[addr]);
        checkValue("rtData", rtData, modelRegs[addr]);
        checkValue("hiData", hiData, modelHi);
        checkValue("loData", loData, modelLo);
    endtask

    // One instruction followed by a bubble, checked in WB and after commit.
    task automatic runInstr(input logic [31:0] alu, input logic [31:0] pcV,
                            input logic [31:0] ob, input logic [31:0] mem,
                            input logic [2:0] lt, input logic [1:0] sel,
                            input logic [4:0] d, input logic [2:0] rw);
        logic [31:0] expected;
        expected = expectedResult(sel, alu, pcV, ob, alignLoad(lt, alu[1:0], mem));
        @(posedge clk);
        #2;
        setInputs(alu, pcV, ob, mem, lt, sel, d, rw);
        @(posedge clk);
        #2;
        regsWr = '0;
        @(posedge clk);
        @(negedge clk);
        checkValue("wbResult", wbResult, expected);
        checkValue("wbDst", 32'(wbDst), 32'(d));
        checkValue("wbRegsWr", 32'(wbRegsWr), 32'(rw));
        checkValue("wbPc", wbPc, pcV);
        commitModel(d, rw, expected);
        checkReg(d);
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================
    task automatic testResultSelect();
        for (int s = 0; s < 3; s++) begin
            runInstr(nextRand(), nextRand(), nextRand(), nextRand(), LoadWord, 2'(s),
                     randReg(), WrRf);
        end
        runInstr(nextRand(), nextRand(), nextRand(), nextRand(), LoadWord, WbSelAlu,
                 5'd0, WrRf);
    endtask

    task automatic testLoadAlign();
        logic [LoadTypeWidth-1:0] types [5];
        logic [31:0]              addr;
        bit                       legal;
        types = '{LoadWord, LoadByte, LoadByteU, LoadHalf, LoadHalfU};
        for (int t = 0; t < 5; t++) begin
            for (int off = 0; off < 4; off++) begin
                legal = !((types[t] == LoadWord && off != 0) ||
                          ((types[t] == LoadHalf || types[t] == LoadHalfU) && off % 2 == 1));
                if (legal) begin
                    addr = nextRand();
                    addr[1:0] = 2'(off);
                    runInstr(addr, nextRand(), nextRand(), nextRand(), types[t], WbSelMem,
                             randReg(), WrRf);
                end
            end
        end
    endtask

    task automatic testPipeline();
        logic [31:0] vals [4];
        for (int k = 0; k < 6; k++) begin
            @(posedge clk);
            #2;
            if (k < 4) begin
                vals[k] = nextRand();
                setInputs(vals[k], 32'h0, 32'h0, 32'h0, LoadWord, WbSelAlu, 5'(10 + k), WrRf);
            end else begin
                regsWr = '0;
            end
            if (k >= 2) begin
                rsAddr = 5'(10 + k - 2);
            end
            @(negedge clk);
            // The write is still pending, so only the bypass can return it.
            if (k >= 2) begin
                checkValue("rsData", rsData, vals[k-2]);
                commitModel(5'(10 + k - 2), WrRf, vals[k-2]);
            end
        end
        for (int k = 0; k < 4; k++) begin
            checkReg(5'(10 + k));
        end
    endtask

    task automatic testStall();
        logic [31:0] va;
        va = nextRand();
        @(posedge clk);
        #2;
        setInputs(va, 32'h0, 32'h0, 32'h0, LoadWord, WbSelAlu, 5'd20, WrRf);
        @(posedge clk);
        #2;
        // A bubble with its own fields sits behind the held instruction.
        setInputs(nextRand(), 32'h0, 32'h0, 32'h0, LoadWord, WbSelAlu, 5'd22, 3'b000);
        @(posedge clk);
        #2;
        wr = 1'b0;
        disWr = 1'b1;
        setInputs(nextRand(), 32'h0, 32'h0, 32'h0, LoadWord, WbSelAlu, 5'd21, WrRf);
        rsAddr = 5'd20;
        repeat (3) begin
            @(negedge clk);
            checkValue("wbResult", wbResult, va);
            checkValue("wbDst", 32'(wbDst), 32'd20);
            checkValue("wbFinalWr", 32'(wbFinalWr), 32'h0);
            checkValue("rsData", rsData, modelRegs[20]);
            @(posedge clk);
            #2;
        end
        wr = 1'b1;
        disWr = 1'b0;
        regsWr = '0;
        @(negedge clk);
        checkValue("wbFinalWr", 32'(wbFinalWr), 32'(WrRf));
        commitModel(5'd20, WrRf, va);
        checkReg(5'd20);
        checkValue("wbRegsWr", 32'(wbRegsWr), 32'h0);
        checkReg(5'd21);
    endtask

    task automatic testFlush();
        runInstr(nextRand(), 32'h0, 32'h0, 32'h0, LoadWord, WbSelAlu, 5'd25, WrRf);
        @(posedge clk);
        #2;
        setInputs(nextRand(), 32'h0, 32'h0, 32'h0, LoadWord, WbSelAlu, 5'd25, WrRf);
        @(posedge clk);
        #2;
        // The instruction now sits in MEM2 and is dropped on the way to WB.
        regsWr = '0;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        @(negedge clk);
        checkValue("wbRegsWr", 32'(wbRegsWr), 32'h0);
        checkReg(5'd25);
    endtask

    task automatic testHiLo();
        runInstr(nextRand(), nextRand(), nextRand(), nextRand(), LoadWord, WbSelOutB, 5'd10, WrHi);
        runInstr(nextRand(), nextRand(), nextRand(), nextRand(), LoadWord, WbSelOutB, 5'd11, WrLo);
        runInstr(nextRand(), nextRand(), nextRand(), nextRand(), LoadWord, WbSelOutB, 5'd12,
                 WrHi | WrLo);
    endtask

    initial begin
        rstN = 1'b0;
        wr = 1'b1;
        flush = 1'b0;
        disWr = 1'b0;
        rsAddr = '0;
        rtAddr = '0;
        setInputs(32'h0, 32'h0, 32'h0, 32'h0, LoadWord, WbSelLink, 5'd0, 3'b000);
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        modelHi = '0;
        modelLo = '0;
        repeat (ResetCycles) @(posedge clk);
        #2;
        rstN = 1'b1;

        testResultSelect();
        testLoadAlign();
        testPipeline();
        testStall();
        testFlush();
        testHiLo();

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== writeback.f ====
src/cpuPkg.sv
src/Mem2WbIf.sv
src/Mem2Stage.sv
src/WbReg.sv
src/WbStage.sv
src/RegFile.sv
src/WritebackTop.sv
verif/wbStage_properties.sv
verif/tbWriteback.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the writeback testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing --assert --top-module tbWriteback \
    --Mdir "$buildDir" -o simWriteback -f writeback.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/simWriteback" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Done: no errors" "$logFile"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
